/* design/fb_pkg.sv */
/*
 * indexed framebuffer shared definitions
 * coordinate and colour types, channel widths and the 16-entry palette
 */
package fb_pkg;

    localparam int CORDW = 16;                 // signed coordinate width
    localparam int CIDXW = 4;                  // colour index width for 16 colours
    localparam int CHANW = 4;                  // bits per rgb channel

    typedef logic signed [CORDW-1:0] coord_t;  // draw coordinate
    typedef logic [CIDXW-1:0] cidx_t;          // colour index
    typedef logic [CHANW-1:0] chan_t;          // one colour channel

    typedef struct packed {
        chan_t red;                            // msb nibble
        chan_t green;
        chan_t blue;                           // lsb nibble
    } rgb_t;

    // index 0 stays black so an untouched buffer shows nothing
    localparam rgb_t PALETTE [2**CIDXW] = '{
        12'h000,                               // 0 black
        12'h126,                               // 1 navy
        12'h725,                               // 2 plum
        12'h085,                               // 3 teal
        12'hA53,                               // 4 brown
        12'h555,                               // 5 dark grey
        12'hCCC,                               // 6 light grey
        12'hFFE,                               // 7 white
        12'hF04,                               // 8 red
        12'hFA0,                               // 9 orange
        12'hFE2,                               // 10 yellow
        12'h0E3,                               // 11 green
        12'h2AF,                               // 12 sky blue
        12'h879,                               // 13 lavender
        12'hF7A,                               // 14 pink
        12'hFCA                                // 15 peach
    };

endpackage

/* design/display_timing.sv */
/*
 * raster timing generator
 * screen position, display enable and line/frame strobes, all registered
 */
module display_timing #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int SCALE     = 2,
    parameter int H_BLANK   = 16,
    parameter int V_BLANK   = 4
) (
    input  logic                     clk_sys,
    input  logic                     rst_sys,
    output logic [fb_pkg::CORDW-1:0] sx,          // column valid with disp_en
    output logic [fb_pkg::CORDW-1:0] sy,          // row switches one cycle early
    output logic                     disp_en,
    output logic                     line_start,  // one cycle before first pixel
    output logic                     frame_start  // line_start of row 0
);

    localparam int H_ACT = FB_WIDTH * SCALE;      // active pixels per line
    localparam int H_TOT = H_ACT + H_BLANK;
    localparam int V_ACT = FB_HEIGHT * SCALE;     // active lines per frame
    localparam int V_TOT = V_ACT + V_BLANK;

    logic [fb_pkg::CORDW-1:0] h;                  // raw horizontal count
    logic [fb_pkg::CORDW-1:0] v;                  // raw vertical count

    // v steps at H_TOT-2 so the line pulse at H_TOT-1 already sees the new row
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            h <= fb_pkg::CORDW'(H_TOT - 2);       // park near end of frame
            v <= fb_pkg::CORDW'(V_TOT - 1);
        end else begin
            h <= (h == fb_pkg::CORDW'(H_TOT - 1)) ? '0 : h + 1'b1;
            if (h == fb_pkg::CORDW'(H_TOT - 2)) begin
                v <= (v == fb_pkg::CORDW'(V_TOT - 1)) ? '0 : v + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx          <= '0;
            sy          <= '0;
            disp_en     <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            sx          <= h;
            sy          <= v;
            disp_en     <= (h < fb_pkg::CORDW'(H_ACT)) && (v < fb_pkg::CORDW'(V_ACT));
            line_start  <= (h == fb_pkg::CORDW'(H_TOT - 1));
            frame_start <= (h == fb_pkg::CORDW'(H_TOT - 1)) && (v == '0);
        end
    end

    a_cnt_range: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (h < fb_pkg::CORDW'(H_TOT)) && (v < fb_pkg::CORDW'(V_TOT)));

endmodule

/* design/draw_port.sv */
/*
 * pixel draw port
 * two-stage write address (row base, then add x) with clip detection
 */
module draw_port #(
    parameter  int FB_WIDTH  = 16,
    parameter  int FB_HEIGHT = 12,
    localparam int ADDRW     = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic                  clk_sys,
    input  logic                  rst_sys,
    input  logic                  we,         // single pixel strobe
    input  fb_pkg::coord_t        x,
    input  fb_pkg::coord_t        y,
    input  fb_pkg::cidx_t         cidx,
    output logic                  clip,       // pulse when the write was out of range
    output logic                  wr_en,
    output logic [ADDRW-1:0]      wr_addr,
    output fb_pkg::cidx_t         wr_data
);

    logic                 out_of_range;
    logic                 we_p1;                // strobe after stage one
    logic [ADDRW-1:0]     row_base;             // FB_WIDTH * y
    logic [ADDRW-1:0]     x_p1;
    fb_pkg::cidx_t        cidx_p1;

    always_comb begin
        out_of_range = (x < 0) || (y < 0) || (x >= FB_WIDTH) || (y >= FB_HEIGHT);
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            clip  <= 1'b0;
            we_p1 <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            clip  <= we && out_of_range;        // stage one
            we_p1 <= we;
            wr_en <= we_p1 && !clip;            // stage two drops clipped writes
        end
    end

    always_ff @(posedge clk_sys) begin
        row_base <= ADDRW'(FB_WIDTH * y);       // only meaningful when in range
        x_p1     <= ADDRW'(x);
        cidx_p1  <= cidx;
        wr_addr  <= row_base + x_p1;
        wr_data  <= cidx_p1;
    end

    // every RAM write traces back to an in-range coordinate two cycles earlier
    a_no_clip_wr: assert property (@(posedge clk_sys) disable iff (rst_sys)
        wr_en |-> ($past(x, 2) >= 0) && ($past(x, 2) < FB_WIDTH) &&
                  ($past(y, 2) >= 0) && ($past(y, 2) < FB_HEIGHT));

endmodule

/* design/framebuffer_ram.sv */
/*
 * single-port pixel memory, one colour index per pixel
 * a write takes the port, a granted read returns data one cycle later
 */
module framebuffer_ram #(
    parameter  int FB_WIDTH  = 16,
    parameter  int FB_HEIGHT = 12,
    localparam int DEPTH     = FB_WIDTH * FB_HEIGHT,
    localparam int ADDRW     = $clog2(DEPTH)
) (
    input  logic             clk_sys,
    input  logic             wr_en,
    input  logic [ADDRW-1:0] wr_addr,
    input  fb_pkg::cidx_t    wr_data,
    input  logic             rd_req,
    input  logic [ADDRW-1:0] rd_addr,
    output logic             rd_ack,      // granted in the same cycle unless writing
    output fb_pkg::cidx_t    rd_data,
    output logic             rd_valid     // one cycle after rd_ack
);

    fb_pkg::cidx_t    mem [DEPTH] = '{default: '0};  // blank image at start
    logic [ADDRW-1:0] addr;                          // shared port address

    assign rd_ack = rd_req && !wr_en;                // draw side always wins
    assign addr   = wr_en ? wr_addr : rd_addr;

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end else if (rd_ack) begin
            rd_data <= mem[addr];
        end
        rd_valid <= rd_ack;
    end

endmodule

/* design/line_fetch_fsm.sv */
/*
 * line fetch FSM
 * copies the next source row from the framebuffer into a line buffer bank
 */
module line_fetch_fsm #(
    parameter  int FB_WIDTH  = 16,
    parameter  int FB_HEIGHT = 12,
    parameter  int SCALE     = 2,
    localparam int ADDRW     = $clog2(FB_WIDTH * FB_HEIGHT),
    localparam int COLW      = $clog2(FB_WIDTH)
) (
    input  logic                     clk_sys,
    input  logic                     rst_sys,
    input  logic [fb_pkg::CORDW-1:0] sy,
    input  logic                     line_start,
    input  logic                     rd_ack,
    input  logic                     rd_valid,
    output logic                     rd_req,
    output logic [ADDRW-1:0]         rd_addr,
    output logic                     lb_we,
    output logic                     lb_bank,   // source row parity
    output logic [COLW-1:0]          lb_col
);

    localparam int V_ACT = FB_HEIGHT * SCALE;

    typedef enum logic [1:0] {
        IDLE,
        READ,     // issuing reads one column per rd_ack
        DRAIN     // waiting for the last rd_valid
    } state_t;

    state_t                   state;
    logic [COLW-1:0]          rd_col;          // next column to request
    logic [fb_pkg::CORDW-1:0] next_row;        // source row to fetch
    logic                     start;

    always_comb begin
        if (sy == fb_pkg::CORDW'(V_ACT)) begin
            next_row = '0;                     // first blank line preloads row 0
        end else begin
            next_row = fb_pkg::CORDW'(sy / SCALE + 1);
        end
        start = line_start && (state == IDLE) &&
                ((sy == fb_pkg::CORDW'(V_ACT)) ||
                 ((sy < fb_pkg::CORDW'(V_ACT)) && (sy % SCALE == 0) &&
                  (next_row < fb_pkg::CORDW'(FB_HEIGHT))));
    end

    assign rd_req = (state == READ);
    assign lb_we  = rd_valid && (state != IDLE);

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state   <= IDLE;
            rd_col  <= '0;
            lb_col  <= '0;
            lb_bank <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state   <= READ;
                    rd_col  <= '0;
                    lb_col  <= '0;
                    lb_bank <= next_row[0];
                end
                READ: if (rd_ack) begin
                    rd_col <= rd_col + 1'b1;
                    if (rd_col == COLW'(FB_WIDTH - 1)) begin
                        state <= DRAIN;        // last request granted
                    end
                end
                DRAIN: if (rd_valid) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
            if (lb_we) begin
                lb_col <= lb_col + 1'b1;       // follows returned data
            end
        end
    end

    // address walks with rd_col
    always_ff @(posedge clk_sys) begin
        if (start) begin
            rd_addr <= ADDRW'(next_row * FB_WIDTH);
        end else if (rd_req && rd_ack) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

/* design/line_buffer.sv */
/*
 * two-bank line buffer
 * fetch writes one bank, display reads the other at sx/SCALE, strobes delayed
 */
module line_buffer #(
    parameter  int  FB_WIDTH = 16,
    parameter  int  SCALE    = 2,
    parameter  type entry_t  = logic [3:0],
    localparam int  COLW     = $clog2(FB_WIDTH)
) (
    input  logic                     clk_sys,
    input  logic                     rst_sys,
    input  logic                     lb_we,
    input  logic                     lb_bank,
    input  logic [COLW-1:0]          lb_col,
    input  entry_t                   rd_data,      // straight from the RAM
    input  logic [fb_pkg::CORDW-1:0] sx,
    input  logic [fb_pkg::CORDW-1:0] sy,
    input  logic                     disp_en,
    input  logic                     line_start,
    input  logic                     frame_start,
    output entry_t                   lb_cidx,
    output logic                     de_d1,
    output logic                     line_d1,
    output logic                     frame_d1
);

    entry_t                   mem [2][FB_WIDTH];   // bank, column
    logic [fb_pkg::CORDW-1:0] src_row;             // display row / SCALE
    logic                     rd_bank;
    logic [COLW-1:0]          rd_col;

    always_comb begin
        src_row = fb_pkg::CORDW'(sy / SCALE);
        rd_bank = src_row[0];                      // even rows in bank 0
        rd_col  = COLW'(sx / SCALE);               // pixel repeat
    end

    always_ff @(posedge clk_sys) begin
        if (lb_we) begin
            mem[lb_bank][lb_col] <= rd_data;
        end
        if (disp_en) begin
            lb_cidx <= mem[rd_bank][rd_col];       // sx out of range in blanking
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de_d1    <= 1'b0;
            line_d1  <= 1'b0;
            frame_d1 <= 1'b0;
        end else begin
            de_d1    <= disp_en;                   // match read latency
            line_d1  <= line_start;
            frame_d1 <= frame_start;
        end
    end

    // fetch stays inside the row and never touches the bank on screen
    a_wr_target: assert property (@(posedge clk_sys) disable iff (rst_sys)
        lb_we |-> (int'(lb_col) < FB_WIDTH) && !(disp_en && (lb_bank == rd_bank)));

endmodule

/* design/palette_stage.sv */
/*
 * palette stage, registered index to rgb lookup, black outside display
 */
module palette_stage (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  fb_pkg::cidx_t lb_cidx,
    input  logic          de_d1,
    input  logic          line_d1,
    input  logic          frame_d1,
    output logic          de,
    output logic          line,
    output logic          frame,
    output fb_pkg::chan_t red,
    output fb_pkg::chan_t green,
    output fb_pkg::chan_t blue
);

    fb_pkg::rgb_t pix;                               // output colour register

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de    <= 1'b0;
            line  <= 1'b0;
            frame <= 1'b0;
            pix   <= '0;
        end else begin
            de    <= de_d1;
            line  <= line_d1;
            frame <= frame_d1;
            pix   <= de_d1 ? fb_pkg::PALETTE[lb_cidx] : '0;  // blank in porch
        end
    end

    assign red   = pix.red;
    assign green = pix.green;
    assign blue  = pix.blue;

endmodule

/* design/indexed_fb.sv */
/*
 * indexed-colour framebuffer top level
 * draw port and raster scan-out sharing one single-port pixel RAM
 */
module indexed_fb #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int SCALE     = 2,
    parameter int H_BLANK   = 16,
    parameter int V_BLANK   = 4
) (
    input  logic           clk_sys,
    input  logic           rst_sys,
    input  logic           we,
    input  fb_pkg::coord_t x,
    input  fb_pkg::coord_t y,
    input  fb_pkg::cidx_t  cidx,
    output logic           clip,
    output logic           de,
    output logic           frame,
    output logic           line,
    output fb_pkg::chan_t  red,
    output fb_pkg::chan_t  green,
    output fb_pkg::chan_t  blue
);

    localparam int ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);
    localparam int COLW  = $clog2(FB_WIDTH);

    logic [fb_pkg::CORDW-1:0] sx, sy;                  // raster position
    logic                     disp_en, line_start, frame_start;
    logic                     wr_en, rd_req, rd_ack, rd_valid;
    logic [ADDRW-1:0]         wr_addr, rd_addr;
    fb_pkg::cidx_t            wr_data, rd_data, lb_cidx;
    logic                     lb_we, lb_bank;
    logic [COLW-1:0]          lb_col;
    logic                     de_d1, line_d1, frame_d1;  // after line buffer read

    display_timing #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE),
        .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
    ) u_timing (
        .clk_sys, .rst_sys, .sx, .sy, .disp_en, .line_start, .frame_start
    );

    draw_port #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_draw (
        .clk_sys, .rst_sys, .we, .x, .y, .cidx, .clip, .wr_en, .wr_addr, .wr_data
    );

    framebuffer_ram #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_ram (
        .clk_sys, .wr_en, .wr_addr, .wr_data,
        .rd_req, .rd_addr, .rd_ack, .rd_data, .rd_valid
    );

    line_fetch_fsm #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE)) u_fetch (
        .clk_sys, .rst_sys, .sy, .line_start, .rd_ack, .rd_valid,
        .rd_req, .rd_addr, .lb_we, .lb_bank, .lb_col
    );

    line_buffer #(.FB_WIDTH(FB_WIDTH), .SCALE(SCALE), .entry_t(fb_pkg::cidx_t)) u_lbuf (
        .clk_sys, .rst_sys, .lb_we, .lb_bank, .lb_col, .rd_data,
        .sx, .sy, .disp_en, .line_start, .frame_start,
        .lb_cidx, .de_d1, .line_d1, .frame_d1
    );

    palette_stage u_pal (
        .clk_sys, .rst_sys, .lb_cidx, .de_d1, .line_d1, .frame_d1,
        .de, .line, .frame, .red, .green, .blue
    );

endmodule

/* sim/tb_indexed_fb.sv */
/*
 * indexed_fb testbench, trace driven with a pixel model
 * checks clip flags, scaled frames against the palette and raster counts
 */
module tb_indexed_fb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FB_WIDTH   = 16;
    localparam int FB_HEIGHT  = 12;
    localparam int SCALE      = 2;
    localparam int H_BLANK    = 16;
    localparam int V_BLANK    = 4;
    localparam int H_ACT      = FB_WIDTH * SCALE;
    localparam int V_ACT      = FB_HEIGHT * SCALE;
    localparam int FRAME_CYC  = (H_ACT + H_BLANK) * (V_ACT + V_BLANK);
    localparam int CLK_PERIOD = 10;

    typedef struct {
        byte kind;                                  // w, p or c
        int  a, b, c, d;
    } rec_t;

    logic           clk_sys;
    logic           rst_sys;
    logic           we;
    fb_pkg::coord_t x, y;
    fb_pkg::cidx_t  cidx;
    logic           clip, de, frame, line;
    fb_pkg::chan_t  red, green, blue;

    fb_pkg::cidx_t  model [FB_HEIGHT][FB_WIDTH];    // expected pixel indices
    rec_t           recs [$];
    logic           exp_clip_in;                    // expectation for current strobe
    logic           exp_clip_d;                     // lined up with dut clip
    logic           run_checks;
    longint         limit_ns;
    int             rec_cycles, n_chk;
    int             de_cnt, de_lines;
    bit             frame_seen;

    indexed_fb #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE),
        .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
    ) dut (
        .clk_sys, .rst_sys, .we, .x, .y, .cidx,
        .clip, .de, .frame, .line, .red, .green, .blue
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    task automatic stop_fail();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_fail();
        end
    endtask

    task automatic check_clip(input bit exp);
        check_flag("clip", clip, exp);
    endtask

    task automatic check_rgb(input fb_pkg::rgb_t exp);
        fb_pkg::rgb_t got;
        got = {red, green, blue};
        if (got !== exp) begin
            $display("[FAIL] %0t rgb got %h expected %h", $time, got, exp);
            stop_fail();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_fail();
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        string ln;
        rec_t  r;
        fd = $fopen("sim/fb_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/fb_trace.txt");
            stop_fail();
        end
        while (!$feof(fd)) begin
            n = $fgets(ln, fd);
            if (n > 0 && ln.getc(0) != "#" && ln.getc(0) != "\n") begin
                r = '{default: 0};
                r.kind = ln.getc(0);
                n = $sscanf(ln.substr(1, ln.len() - 1), "%d %d %d %d", r.a, r.b, r.c, r.d);
                case (r.kind)
                    "w": rec_cycles += 1;
                    "p": rec_cycles += r.a;
                    "c": n_chk += 1;
                    default: begin
                        $display("unknown record in the trace file: %s", ln);
                        stop_fail();
                    end
                endcase
                recs.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_write(input int wx, input int wy, input int wc, input int wclip);
        @(posedge clk_sys);
        we          <= 1'b1;
        x           <= fb_pkg::coord_t'(wx);
        y           <= fb_pkg::coord_t'(wy);
        cidx        <= fb_pkg::cidx_t'(wc);
        exp_clip_in <= wclip[0];
        if (wx >= 0 && wx < FB_WIDTH && wy >= 0 && wy < FB_HEIGHT) begin
            model[wy][wx] = fb_pkg::cidx_t'(wc);    // clipped writes never land
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            we          <= 1'b0;
            exp_clip_in <= 1'b0;
        end
    endtask

    task automatic wait_frame();
        do @(negedge clk_sys); while (!frame);
    endtask

    // second frame after the writes is fetched entirely from settled memory
    task automatic check_frame();
        int row;
        int col;
        wait_frame();
        wait_frame();
        row = 0;
        col = 0;
        while (!(row == V_ACT - 1 && col == H_ACT)) begin
            @(negedge clk_sys);
            if (line) begin
                row++;
                col = 0;
            end
            if (de) begin
                if (row >= V_ACT || col >= H_ACT) begin
                    $display("de was high outside the active area at row %0d col %0d", row, col);
                    stop_fail();
                end
                check_rgb(fb_pkg::PALETTE[model[row / SCALE][col / SCALE]]);
                col++;
            end
        end
    endtask

    always @(posedge clk_sys) exp_clip_d <= exp_clip_in;   // clip is one cycle late

    // raster monitor runs through every frame including the write burst
    always @(negedge clk_sys) begin
        if (run_checks) begin
            check_clip(exp_clip_d);
            if (!de) begin
                check_rgb('0);                      // blank outside display
            end
            if (line) begin
                if (de_cnt > 0) begin
                    check_count("de cycles per line", de_cnt, H_ACT);
                    de_lines++;
                end
                de_cnt = 0;
            end
            if (frame) begin
                check_flag("line", line, 1'b1);     // frame rides on the row 0 line pulse
                if (frame_seen) begin
                    check_count("de lines per frame", de_lines, V_ACT);
                end
                de_lines   = 0;
                frame_seen = 1'b1;
            end
            if (de) begin
                de_cnt++;
            end
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout, the trace did not complete within %0d ns", limit_ns);
        stop_fail();
    end

    initial begin
        clk_sys     = 1'b0;
        rst_sys     = 1'b1;
        we          = 1'b0;
        x           = '0;
        y           = '0;
        cidx        = '0;
        exp_clip_in = 1'b0;
        exp_clip_d  = 1'b0;
        run_checks  = 1'b0;
        foreach (model[r, c]) model[r][c] = '0;     // dut ram starts blank
        load_trace();
        limit_ns = longint'(8 + rec_cycles + (n_chk + 2) * 3 * FRAME_CYC) * CLK_PERIOD;
        repeat (8) @(posedge clk_sys);
        rst_sys    <= 1'b0;
        run_checks <= 1'b1;
        @(negedge clk_sys);
        while (!frame) begin                        // quiet until the first frame pulse
            check_flag("de", de, 1'b0);
            check_flag("line", line, 1'b0);
            check_clip(1'b0);
            check_rgb('0);
            @(negedge clk_sys);
        end
        foreach (recs[i]) begin
            case (recs[i].kind)
                "w": apply_write(recs[i].a, recs[i].b, recs[i].c, recs[i].d);
                "p": idle_cycles(recs[i].a);
                default: begin
                    idle_cycles(1);
                    check_frame();
                end
            endcase
        end
        idle_cycles(4);                             // flush last clip checks
        $display("Test passed");
        $finish;
    end

endmodule

/* sim/fb_trace.txt */
# w <x> <y> <cidx> <clip>  pixel write, clip is the expected flag
# p <cycles>  idle cycles, c  compare one full frame with the model
p 5
w 0 0 1 0
w 15 0 2 0
w 0 11 3 0
w 15 11 4 0
w 0 1 5 0
w 16 0 9 1
w -1 2 8 1
w 4 -3 8 1
w 2 12 8 1
w 7 5 10 0
p 3
w 3 4 2 0
w 3 4 11 0
w 3 4 14 0
w 8 6 12 0
w 9 7 13 0
c
p 215
w 1 0 7 0
w 2 1 8 0
w 3 2 9 0
w 4 3 10 0
w 5 4 11 0
w 20 5 1 1
w 6 5 12 0
w 7 6 13 0
w 9 8 15 0
w 12 11 4 0
w 15 11 0 0
c

/* indexed_fb.f */
design/fb_pkg.sv
design/display_timing.sv
design/draw_port.sv
design/framebuffer_ram.sv
design/line_fetch_fsm.sv
design/line_buffer.sv
design/palette_stage.sv
design/indexed_fb.sv
sim/tb_indexed_fb.sv

/* Makefile */
SIM      = verilator
TOP      = tb_indexed_fb
FILELIST = indexed_fb.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
EXE      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(EXE)

clean:
	rm -rf $(OBJ_DIR)
